// File: hdl/exu_config.svh
// RV32I widths only. Just the ALU, lui, auipc and jump opcode classes are listed
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

// one data word
`define EXU_XLEN        32
// register index, 32 architectural registers
`define EXU_REG_ADDR_W  5
// one bit per alu operation
`define EXU_ALU_OP_W    13

//////////////////////////////////////////////////
// major opcodes in inst[6:0]
//////////////////////////////////////////////////

// register-register alu
`define EXU_OPC_OP      7'b0110011
// register-immediate alu
`define EXU_OPC_OP_IMM  7'b0010011
`define EXU_OPC_LUI     7'b0110111
`define EXU_OPC_AUIPC   7'b0010111
// both jumps only write the link value
`define EXU_OPC_JAL     7'b1101111
`define EXU_OPC_JALR    7'b1100111

`endif

// File: hdl/exu_pkg.sv
// Types shared by the execute slice. Widths come from the config header
`default_nettype none
`include "exu_config.svh"

package exu_pkg;

    // one data word
    typedef logic [`EXU_XLEN-1:0] xlen_t;

    // architectural register index
    typedef logic [`EXU_REG_ADDR_W-1:0] reg_addr_t;

    // bit positions in the one-hot op vector
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_LUI   = 4'd10,
        ALU_AUIPC = 4'd11,
        ALU_JUMP  = 4'd12
    } alu_op_e;

    // at most one bit set, all zero for non-alu opcodes
    typedef logic [`EXU_ALU_OP_W-1:0] alu_op_t;

    // decode to alu, 84 bits
    typedef struct packed {
        logic      req;
        alu_op_t   op;
        xlen_t     op1;
        xlen_t     op2;
        reg_addr_t rd;
        logic      we;
    } alu_issue_t;

    // alu output register, also the forwarding source
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
    } alu_result_t;

endpackage

`default_nettype wire

// File: hdl/exu_decode.sv
// Purely combinational. Non-ALU opcodes issue with no op bit and no write
`timescale 1ns/100ps
`default_nettype none
`include "exu_config.svh"

module exu_decode (
    input  wire logic                 inst_valid_i,
    input  wire exu_pkg::xlen_t       inst_i,
    input  wire exu_pkg::xlen_t       pc_i,
    input  wire exu_pkg::xlen_t       rs1_data_i,
    input  wire exu_pkg::xlen_t       rs2_data_i,
    input  wire exu_pkg::alu_result_t fwd_i,
    output exu_pkg::reg_addr_t        rs1_addr_o,
    output exu_pkg::reg_addr_t        rs2_addr_o,
    output exu_pkg::alu_issue_t       issue_o
);

    // link value added to pc for jal/jalr
    localparam exu_pkg::xlen_t LINK_OFS = exu_pkg::xlen_t'(4);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               funct7_b30;
    exu_pkg::reg_addr_t rd;
    exu_pkg::reg_addr_t rs1;
    exu_pkg::reg_addr_t rs2;
    exu_pkg::xlen_t     imm_i;
    exu_pkg::xlen_t     imm_u;
    logic               is_op;
    logic               is_op_imm;
    logic               is_lui;
    logic               is_auipc;
    logic               is_jump;
    logic               fwd_rs1;
    logic               fwd_rs2;
    exu_pkg::xlen_t     rs1_val;
    exu_pkg::xlen_t     rs2_val;
    exu_pkg::alu_op_t   alu_op;

    //////////////////////////////////////////////////
    // field extraction
    //////////////////////////////////////////////////
    assign opcode     = inst_i[6:0];
    assign rd         = inst_i[11:7];
    assign funct3     = inst_i[14:12];
    assign rs1        = inst_i[19:15];
    assign rs2        = inst_i[24:20];
    assign funct7_b30 = inst_i[30];

    // sign-extended 12-bit immediate
    assign imm_i = {{(`EXU_XLEN-12){inst_i[31]}}, inst_i[31:20]};
    // upper immediate, low 12 bits zero
    assign imm_u = {inst_i[31:12], 12'b0};

    // opcode classes
    assign is_op     = (opcode == `EXU_OPC_OP);
    assign is_op_imm = (opcode == `EXU_OPC_OP_IMM);
    assign is_lui    = (opcode == `EXU_OPC_LUI);
    assign is_auipc  = (opcode == `EXU_OPC_AUIPC);
    assign is_jump   = (opcode == `EXU_OPC_JAL) || (opcode == `EXU_OPC_JALR);

    //////////////////////////////////////////////////
    // operation mapping
    //////////////////////////////////////////////////
    always_comb begin
        alu_op = '0;
        if (is_op || is_op_imm) begin
            case (funct3)
                3'b000: begin
                    // op-imm has no subtract
                    if (is_op && funct7_b30) begin
                        alu_op[exu_pkg::ALU_SUB] = 1'b1;
                    end else begin
                        alu_op[exu_pkg::ALU_ADD] = 1'b1;
                    end
                end
                3'b001: alu_op[exu_pkg::ALU_SLL]  = 1'b1;
                3'b010: alu_op[exu_pkg::ALU_SLT]  = 1'b1;
                3'b011: alu_op[exu_pkg::ALU_SLTU] = 1'b1;
                3'b100: alu_op[exu_pkg::ALU_XOR]  = 1'b1;
                3'b101: begin
                    // bit 30 picks arithmetic shift for both forms
                    if (funct7_b30) begin
                        alu_op[exu_pkg::ALU_SRA] = 1'b1;
                    end else begin
                        alu_op[exu_pkg::ALU_SRL] = 1'b1;
                    end
                end
                3'b110: alu_op[exu_pkg::ALU_OR]   = 1'b1;
                default: alu_op[exu_pkg::ALU_AND] = 1'b1;
            endcase
        end else if (is_lui) begin
            alu_op[exu_pkg::ALU_LUI] = 1'b1;
        end else if (is_auipc) begin
            alu_op[exu_pkg::ALU_AUIPC] = 1'b1;
        end else if (is_jump) begin
            alu_op[exu_pkg::ALU_JUMP] = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // operand read with forwarding
    //////////////////////////////////////////////////
    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    // held write beats the register file, x0 never forwarded
    assign fwd_rs1 = fwd_i.we && (fwd_i.rd == rs1) && (rs1 != '0);
    assign fwd_rs2 = fwd_i.we && (fwd_i.rd == rs2) && (rs2 != '0);

    assign rs1_val = fwd_rs1 ? fwd_i.data : rs1_data_i;
    assign rs2_val = fwd_rs2 ? fwd_i.data : rs2_data_i;

    //////////////////////////////////////////////////
    // issue struct
    //////////////////////////////////////////////////
    assign issue_o.req = inst_valid_i;
    assign issue_o.op  = alu_op;
    assign issue_o.rd  = rd;

    // pc based ops take pc as first operand
    assign issue_o.op1 = (is_auipc || is_jump) ? pc_i : rs1_val;

    // second operand by format
    assign issue_o.op2 = is_op               ? rs2_val  :
                         is_jump             ? LINK_OFS :
                         (is_lui || is_auipc) ? imm_u   :
                                                imm_i;

    // writes only for alu classes, never to x0
    assign issue_o.we = (is_op || is_op_imm || is_lui || is_auipc || is_jump) && (rd != '0);

endmodule

`default_nettype wire

// File: hdl/exu_alu.sv
// One-cycle ALU. The output register holds under back-pressure and an interrupt kills the write
`timescale 1ns/100ps
`default_nettype none
`include "exu_config.svh"

module exu_alu (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire exu_pkg::alu_issue_t issue_i,
    input  wire logic                int_assert_i,
    input  wire logic                wb_ready_i,
    output exu_pkg::alu_result_t     result_o,
    output logic                     alu_stall_o
);

    localparam int SHAMT_W = $clog2(`EXU_XLEN);

    // mirror a word, used around the left shifter
    function automatic exu_pkg::xlen_t bit_rev(input exu_pkg::xlen_t val);
        exu_pkg::xlen_t rev;
        for (int i = 0; i < `EXU_XLEN; i++) begin
            rev[i] = val[`EXU_XLEN-1-i];
        end
        return rev;
    endfunction

    exu_pkg::xlen_t       op1;
    exu_pkg::xlen_t       op2;
    exu_pkg::xlen_t       shift_in;
    logic [SHAMT_W-1:0]   shamt;
    exu_pkg::xlen_t       shift_res;
    exu_pkg::xlen_t       shift_mask;
    exu_pkg::xlen_t       srl_res;
    exu_pkg::xlen_t       sra_res;
    exu_pkg::xlen_t       adder_in1;
    exu_pkg::xlen_t       adder_in2;
    logic                 adder_cin;
    logic [`EXU_XLEN:0]   adder_res;
    logic                 is_lt_signed;
    logic                 is_lt_unsigned;
    exu_pkg::xlen_t       alu_res;
    logic                 load_we;
    logic                 update;
    exu_pkg::alu_result_t result_d;
    exu_pkg::alu_result_t result_q;

    assign op1 = issue_i.op1;
    assign op2 = issue_i.op2;

    // one-hot decode of the op vector
    wire op_add   = issue_i.op[exu_pkg::ALU_ADD];
    wire op_sub   = issue_i.op[exu_pkg::ALU_SUB];
    wire op_sll   = issue_i.op[exu_pkg::ALU_SLL];
    wire op_slt   = issue_i.op[exu_pkg::ALU_SLT];
    wire op_sltu  = issue_i.op[exu_pkg::ALU_SLTU];
    wire op_xor   = issue_i.op[exu_pkg::ALU_XOR];
    wire op_srl   = issue_i.op[exu_pkg::ALU_SRL];
    wire op_sra   = issue_i.op[exu_pkg::ALU_SRA];
    wire op_or    = issue_i.op[exu_pkg::ALU_OR];
    wire op_and   = issue_i.op[exu_pkg::ALU_AND];
    wire op_lui   = issue_i.op[exu_pkg::ALU_LUI];
    wire op_auipc = issue_i.op[exu_pkg::ALU_AUIPC];
    wire op_jump  = issue_i.op[exu_pkg::ALU_JUMP];

    // groups sharing a datapath
    wire op_right   = op_srl | op_sra;
    wire op_shift   = op_sll | op_right;
    wire op_compare = op_slt | op_sltu;
    wire adder_op   = op_add | op_sub | op_compare | op_auipc | op_jump;
    wire adder_inv  = op_sub | op_compare;

    //////////////////////////////////////////////////
    // shifter
    //////////////////////////////////////////////////
    // right shifts go through the left shifter mirrored
    assign shift_in  = {`EXU_XLEN{op_shift}} & (op_right ? bit_rev(op1) : op1);
    assign shamt     = {SHAMT_W{op_shift}} & op2[SHAMT_W-1:0];
    assign shift_res = shift_in << shamt;
    assign srl_res   = bit_rev(shift_res);

    // vacated upper bits get the sign for sra
    assign shift_mask = ~({`EXU_XLEN{1'b1}} >> shamt);
    assign sra_res    = (srl_res & ~shift_mask) | ({`EXU_XLEN{op1[`EXU_XLEN-1]}} & shift_mask);

    //////////////////////////////////////////////////
    // adder
    //////////////////////////////////////////////////
    // sub and compares do op1 + ~op2 + 1
    assign adder_in1 = {`EXU_XLEN{adder_op}} & op1;
    assign adder_in2 = {`EXU_XLEN{adder_op}} & (adder_inv ? ~op2 : op2);
    assign adder_cin = adder_op & adder_inv;
    assign adder_res = {1'b0, adder_in1} + {1'b0, adder_in2} + {{`EXU_XLEN{1'b0}}, adder_cin};

    // signs differ means the negative one is smaller
    assign is_lt_signed = (op1[`EXU_XLEN-1] != op2[`EXU_XLEN-1]) ? op1[`EXU_XLEN-1]
                                                                  : adder_res[`EXU_XLEN-1];
    // no carry out means a borrow
    assign is_lt_unsigned = ~adder_res[`EXU_XLEN];

    //////////////////////////////////////////////////
    // result select, and-or
    //////////////////////////////////////////////////
    assign alu_res =
        ({`EXU_XLEN{op_add | op_sub | op_auipc | op_jump}} & adder_res[`EXU_XLEN-1:0]) |
        ({`EXU_XLEN{op_sll}}  & shift_res) |
        ({`EXU_XLEN{op_srl}}  & srl_res) |
        ({`EXU_XLEN{op_sra}}  & sra_res) |
        ({`EXU_XLEN{op_slt}}  & exu_pkg::xlen_t'(is_lt_signed)) |
        ({`EXU_XLEN{op_sltu}} & exu_pkg::xlen_t'(is_lt_unsigned)) |
        ({`EXU_XLEN{op_xor}}  & (op1 ^ op2)) |
        ({`EXU_XLEN{op_or}}   & (op1 | op2)) |
        ({`EXU_XLEN{op_and}}  & (op1 & op2)) |
        ({`EXU_XLEN{op_lui}}  & op2);

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////
    // interrupt level kills the accepted write
    assign load_we = issue_i.req & issue_i.we & ~int_assert_i;

    // empty entries carry rd and data zero
    assign result_d.we   = load_we;
    assign result_d.rd   = load_we ? issue_i.rd : '0;
    assign result_d.data = load_we ? alu_res : '0;

    // free when retired this edge or holding nothing
    assign update = wb_ready_i | ~result_q.we;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_q <= '0;
        end else if (update) begin
            result_q <= result_d;
        end
    end

    // held write not taken by retire
    assign alu_stall_o = result_q.we & ~wb_ready_i;
    assign result_o    = result_q;

endmodule

`default_nettype wire

// File: hdl/exu_result.sv
// Register file with x0 wired to zero. Writes only on a retire handshake
`timescale 1ns/100ps
`default_nettype none
`include "exu_config.svh"

module exu_result (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire exu_pkg::alu_result_t result_i,
    input  wire logic                 ret_ready_i,
    input  wire exu_pkg::reg_addr_t   rs1_addr_i,
    input  wire exu_pkg::reg_addr_t   rs2_addr_i,
    output exu_pkg::xlen_t            rs1_data_o,
    output exu_pkg::xlen_t            rs2_data_o,
    output logic                      ret_valid_o,
    output exu_pkg::reg_addr_t        ret_rd_o,
    output exu_pkg::xlen_t            ret_data_o
);

    localparam int NUM_REGS = 1 << `EXU_REG_ADDR_W;

    // x1..x31 only
    exu_pkg::xlen_t regs [1:NUM_REGS-1];
    logic           commit;

    //////////////////////////////////////////////////
    // retire port
    //////////////////////////////////////////////////
    // straight from the alu output register
    assign ret_valid_o = result_i.we;
    assign ret_rd_o    = result_i.rd;
    assign ret_data_o  = result_i.data;

    // handshake on this edge
    assign commit = ret_valid_o & ret_ready_i;

    //////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit && (result_i.rd != '0)) begin
            regs[result_i.rd] <= result_i.data;
        end
    end

    // combinational reads, x0 is zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// File: hdl/exu_top.sv
// Execute slice top. Instructions other than ALU ops, lui, auipc and jumps retire nothing
`timescale 1ns/100ps
`default_nettype none

module exu_top (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,
    // instruction in
    input  wire logic           inst_valid_i,
    input  wire exu_pkg::xlen_t inst_i,
    input  wire exu_pkg::xlen_t pc_i,
    output logic                inst_ready_o,
    // interrupt level
    input  wire logic           int_assert_i,
    // retire port
    output logic                ret_valid_o,
    output exu_pkg::reg_addr_t  ret_rd_o,
    output exu_pkg::xlen_t      ret_data_o,
    input  wire logic           ret_ready_i
);

    exu_pkg::alu_issue_t  issue;
    exu_pkg::alu_result_t alu_result;
    exu_pkg::reg_addr_t   rs1_addr;
    exu_pkg::reg_addr_t   rs2_addr;
    exu_pkg::xlen_t       rs1_data;
    exu_pkg::xlen_t       rs2_data;
    logic                 alu_stall;

    // no acceptance while the output register is held
    assign inst_ready_o = ~alu_stall;

    //////////////////////////////////////////////////
    // decode, execute, result
    //////////////////////////////////////////////////
    exu_decode u_decode (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .fwd_i        (alu_result),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .issue_o      (issue)
    );

    exu_alu u_alu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .issue_i      (issue),
        .int_assert_i (int_assert_i),
        .wb_ready_i   (ret_ready_i),
        .result_o     (alu_result),
        .alu_stall_o  (alu_stall)
    );

    // retire back-pressure also gates the commit
    exu_result u_result (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .result_i     (alu_result),
        .ret_ready_i  (ret_ready_i),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .ret_valid_o  (ret_valid_o),
        .ret_rd_o     (ret_rd_o),
        .ret_data_o   (ret_data_o)
    );

endmodule

`default_nettype wire

// File: sim/exu_tb.sv
// Self-checking testbench. Back-pressure is random from a fixed seed and each wait has a timeout
`timescale 1ns/100ps
`default_nettype none
`include "exu_config.svh"

module exu_tb;

    localparam int TIMEOUT = 200;

    logic               clk_i;
    logic               rst_n_i;
    logic               inst_valid_i;
    exu_pkg::xlen_t     inst_i;
    exu_pkg::xlen_t     pc_i;
    logic               inst_ready_o;
    logic               int_assert_i;
    logic               ret_valid_o;
    exu_pkg::reg_addr_t ret_rd_o;
    exu_pkg::xlen_t     ret_data_o;
    logic               ret_ready_i;

    // stimulus table with one row per test
    string              tbl_name[$];
    exu_pkg::xlen_t     tbl_inst[$];
    exu_pkg::xlen_t     tbl_pc[$];
    logic               tbl_irq[$];
    logic               tbl_ret[$];

    // expected retires in order, oldest first
    string              exp_name[$];
    exu_pkg::reg_addr_t exp_rd[$];
    exu_pkg::xlen_t     exp_data[$];

    // architectural state of the model
    exu_pkg::xlen_t     shadow [0:31];
    int                 errors;
    int                 checks;
    int                 tests;
    int                 mon_errs;
    logic               bp_on;
    logic               held;
    exu_pkg::reg_addr_t held_rd;
    exu_pkg::xlen_t     held_data;

    exu_top uut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .inst_ready_o (inst_ready_o),
        .int_assert_i (int_assert_i),
        .ret_valid_o  (ret_valid_o),
        .ret_rd_o     (ret_rd_o),
        .ret_data_o   (ret_data_o),
        .ret_ready_i  (ret_ready_i)
    );

    always #2 clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_data(input string name, input exu_pkg::xlen_t exp,
                              input exu_pkg::xlen_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_rd(input string name, input exu_pkg::reg_addr_t exp,
                            input exu_pkg::reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected x%0d actual x%0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // instruction encoders
    //////////////////////////////////////////////////
    function automatic exu_pkg::xlen_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                              input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `EXU_OPC_OP};
    endfunction

    function automatic exu_pkg::xlen_t i_type(input int imm, input int rs1, input logic [2:0] f3,
                                              input int rd, input logic [6:0] opc);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic exu_pkg::xlen_t u_type(input int imm, input int rd, input logic [6:0] opc);
        return {20'(imm), 5'(rd), opc};
    endfunction

    //////////////////////////////////////////////////
    // rv32i reference model
    //////////////////////////////////////////////////
    function automatic exu_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                               input logic is_sub, input exu_pkg::xlen_t a,
                                               input exu_pkg::xlen_t b);
        case (f3)
            3'd0: return is_sub ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return exu_pkg::xlen_t'($signed(a) < $signed(b));
            3'd3: return exu_pkg::xlen_t'(a < b);
            3'd4: return a ^ b;
            3'd5: begin
                // arithmetic when bit 30 is set
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // result of one accepted instruction with the shadow updated in program order
    task automatic predict(input exu_pkg::xlen_t inst, input exu_pkg::xlen_t pc, input logic irq,
                           output exu_pkg::reg_addr_t rd, output exu_pkg::xlen_t data);
        exu_pkg::xlen_t a;
        exu_pkg::xlen_t imm;
        logic           writes;
        a      = shadow[inst[19:15]];
        imm    = {{20{inst[31]}}, inst[31:20]};
        rd     = inst[11:7];
        writes = 1'b1;
        case (inst[6:0])
            `EXU_OPC_OP:     data = alu_ref(inst[14:12], inst[30], inst[30], a,
                                            shadow[inst[24:20]]);
            `EXU_OPC_OP_IMM: data = alu_ref(inst[14:12], inst[30], 1'b0, a, imm);
            `EXU_OPC_LUI:    data = {inst[31:12], 12'b0};
            `EXU_OPC_AUIPC:  data = pc + {inst[31:12], 12'b0};
            `EXU_OPC_JAL, `EXU_OPC_JALR: data = pc + 32'd4;
            default: begin
                writes = 1'b0;
                data   = '0;
            end
        endcase
        if (writes && !irq && (rd != '0)) begin
            shadow[rd] = data;
        end
    endtask

    task automatic add_test(input string name, input exu_pkg::xlen_t inst,
                            input exu_pkg::xlen_t pc, input logic irq, input logic ret);
        tbl_name.push_back(name);
        tbl_inst.push_back(inst);
        tbl_pc.push_back(pc);
        tbl_irq.push_back(irq);
        tbl_ret.push_back(ret);
    endtask

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////
    task automatic build_table();
        // set up x1 = 0x80000000, x2 = -5 and x3 = 7
        add_test("lui x1", u_type(32'h80000, 1, `EXU_OPC_LUI), 0, 0, 1);
        add_test("addi neg", i_type(-5, 0, 3'd0, 2, `EXU_OPC_OP_IMM), 0, 0, 1);
        add_test("addi pos", i_type(7, 0, 3'd0, 3, `EXU_OPC_OP_IMM), 0, 0, 1);
        // back to back so x3 comes from the output register
        add_test("add fwd", r_type(7'h00, 3, 2, 3'd0, 4), 0, 0, 1);
        add_test("sub", r_type(7'h20, 2, 3, 3'd0, 5), 0, 0, 1);
        add_test("and", r_type(7'h00, 3, 2, 3'd7, 6), 0, 0, 1);
        add_test("or", r_type(7'h00, 3, 2, 3'd6, 7), 0, 0, 1);
        add_test("xor", r_type(7'h00, 3, 2, 3'd4, 8), 0, 0, 1);
        add_test("andi", i_type(240, 2, 3'd7, 9, `EXU_OPC_OP_IMM), 0, 0, 1);
        add_test("ori", i_type(-256, 3, 3'd6, 10, `EXU_OPC_OP_IMM), 0, 0, 1);
        add_test("xori", i_type(-1, 2, 3'd4, 11, `EXU_OPC_OP_IMM), 0, 0, 1);
        add_test("sll reg", r_type(7'h00, 3, 2, 3'd1, 12), 0, 0, 1);
        add_test("srl reg", r_type(7'h00, 3, 2, 3'd5, 13), 0, 0, 1);
        add_test("sra reg", r_type(7'h20, 3, 2, 3'd5, 14), 0, 0, 1);
        add_test("slli 0", i_type(0, 2, 3'd1, 15, `EXU_OPC_OP_IMM), 0, 0, 1);
        add_test("srli 31", i_type(31, 2, 3'd5, 16, `EXU_OPC_OP_IMM), 0, 0, 1);
        add_test("srai 31", i_type(1024 + 31, 1, 3'd5, 17, `EXU_OPC_OP_IMM), 0, 0, 1);
        add_test("srai 0", i_type(1024, 2, 3'd5, 18, `EXU_OPC_OP_IMM), 0, 0, 1);
        add_test("slt mixed", r_type(7'h00, 3, 2, 3'd2, 19), 0, 0, 1);
        add_test("sltu mixed", r_type(7'h00, 3, 2, 3'd3, 20), 0, 0, 1);
        add_test("slt equal", r_type(7'h00, 3, 3, 3'd2, 21), 0, 0, 1);
        add_test("sltu equal", r_type(7'h00, 2, 2, 3'd3, 30), 0, 0, 1);
        add_test("sltiu", i_type(-1, 3, 3'd3, 22, `EXU_OPC_OP_IMM), 0, 0, 1);
        add_test("auipc", u_type(32'h12345, 23, `EXU_OPC_AUIPC), 32'h100, 0, 1);
        add_test("jal", u_type(32'h00010, 24, `EXU_OPC_JAL), 32'h200, 0, 1);
        add_test("jalr", i_type(8, 1, 3'd0, 25, `EXU_OPC_JALR), 32'h300, 0, 1);
        // dependent chain through the output register
        add_test("chain a", i_type(1, 4, 3'd0, 26, `EXU_OPC_OP_IMM), 0, 0, 1);
        add_test("chain b", r_type(7'h00, 26, 26, 3'd0, 27), 0, 0, 1);
        add_test("irq kill", i_type(100, 3, 3'd0, 3, `EXU_OPC_OP_IMM), 0, 1, 0);
        add_test("read after kill", r_type(7'h00, 0, 3, 3'd0, 28), 0, 0, 1);
        add_test("write x0", i_type(5, 0, 3'd0, 0, `EXU_OPC_OP_IMM), 0, 0, 0);
        add_test("store ignored", i_type(0, 1, 3'd2, 5, 7'b0100011), 0, 0, 0);
        add_test("branch ignored", i_type(0, 1, 3'd0, 8, 7'b1100011), 0, 0, 0);
        add_test("read x0", r_type(7'h00, 0, 0, 3'd0, 29), 0, 0, 1);
    endtask

    //////////////////////////////////////////////////
    // back-pressure and retire monitor
    //////////////////////////////////////////////////
    always @(posedge clk_i) begin
        #1;
        if (bp_on) begin
            ret_ready_i = ($urandom % 3) != 0;
        end
    end

    // outputs sampled mid-cycle where they equal the next edge's values
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (held) begin
                check_flag("hold ret_valid", 1'b1, ret_valid_o);
                check_rd("hold ret_rd", held_rd, ret_rd_o);
                check_data("hold ret_data", held_data, ret_data_o);
            end
            held      = ret_valid_o && !ret_ready_i;
            held_rd   = ret_rd_o;
            held_data = ret_data_o;
            if (held) begin
                check_flag("hold inst_ready", 1'b0, inst_ready_o);
            end
            if (ret_valid_o && ret_ready_i) begin
                if (exp_name.size() == 0) begin
                    errors++;
                    $display("retire of x%0d with no instruction expected to retire", ret_rd_o);
                end else begin
                    mon_errs = errors;
                    check_rd(exp_name[0], exp_rd[0], ret_rd_o);
                    check_data(exp_name[0], exp_data[0], ret_data_o);
                    if (errors == mon_errs) begin
                        $display("PASSED %s", exp_name[0]);
                    end
                    tests++;
                    void'(exp_name.pop_front());
                    void'(exp_rd.pop_front());
                    void'(exp_data.pop_front());
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        int                 idx;
        int                 wait_cnt;
        logic               accepted;
        logic               timed_out;
        exu_pkg::reg_addr_t rd;
        exu_pkg::xlen_t     data;
        void'($urandom(32'h40ee69b5));
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        int_assert_i = 1'b0;
        ret_ready_i  = 1'b1;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        bp_on        = 1'b0;
        held         = 1'b0;
        timed_out    = 1'b0;
        for (idx = 0; idx < 32; idx++) begin
            shadow[idx] = '0;
        end
        build_table();
        repeat (8) @(posedge clk_i);
        #1 rst_n_i = 1'b1;

        // idle state after reset
        @(negedge clk_i);
        mon_errs = errors;
        check_flag("reset ret_valid", 1'b0, ret_valid_o);
        check_flag("reset inst_ready", 1'b1, inst_ready_o);
        check_rd("reset ret_rd", '0, ret_rd_o);
        check_data("reset ret_data", '0, ret_data_o);
        if (errors == mon_errs) begin
            $display("PASSED reset state");
        end
        tests++;

        bp_on = 1'b1;
        @(posedge clk_i);
        #1;
        for (idx = 0; idx < tbl_inst.size() && !timed_out; idx++) begin
            inst_valid_i = 1'b1;
            inst_i       = tbl_inst[idx];
            pc_i         = tbl_pc[idx];
            int_assert_i = tbl_irq[idx];
            accepted     = 1'b0;
            wait_cnt     = 0;
            while (!accepted && wait_cnt < TIMEOUT) begin
                @(negedge clk_i);
                accepted = inst_ready_o;
                wait_cnt++;
            end
            if (!accepted) begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: %s was never accepted", tbl_name[idx]);
            end else begin
                predict(tbl_inst[idx], tbl_pc[idx], tbl_irq[idx], rd, data);
                if (tbl_ret[idx]) begin
                    exp_name.push_back(tbl_name[idx]);
                    exp_rd.push_back(rd);
                    exp_data.push_back(data);
                end else begin
                    tests++;
                    $display("PASSED %s accepted, no retire expected", tbl_name[idx]);
                end
            end
            @(posedge clk_i);
            #1;
        end
        inst_valid_i = 1'b0;
        int_assert_i = 1'b0;

        // drain the remaining retires
        wait_cnt = 0;
        while ((exp_name.size() != 0 || ret_valid_o) && wait_cnt < TIMEOUT) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        if (exp_name.size() != 0 || ret_valid_o) begin
            errors++;
            $display("timeout: %0d expected retires never happened", exp_name.size());
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+hdl
hdl/exu_pkg.sv
hdl/exu_decode.sv
hdl/exu_alu.sv
hdl/exu_result.sv
hdl/exu_top.sv
sim/exu_tb.sv
